//--- hw/mem_sys_pkg.sv
////////////////////
// memory system package
// shared widths, the tagged bus command encoding
// and the cache miss state machine encoding
////////////////////

package mem_sys_pkg;

	////////////////////
	// widths
	////////////////////

	// byte address
	typedef logic [31:0] addr_t;

	// one memory block, also one cache line
	typedef logic [63:0] block_t;

	// memory transaction tag, zero means no tag
	typedef logic [3:0] mem_tag_t;

	// byte offset inside a 64-bit block
	localparam int BLOCK_OFFSET_BITS = 3;

	////////////////////
	// encodings
	////////////////////

	// command on the memory bus and on the data cache port
	typedef enum logic [1:0] {
		BUS_NONE  = 2'h0,
		BUS_LOAD  = 2'h1,
		BUS_STORE = 2'h2
	} bus_cmd_e;

	// miss handling, shared by both caches
	typedef enum logic [1:0] {
		CACHE_IDLE        = 2'h0,
		CACHE_WAIT_ACCEPT = 2'h1,
		CACHE_WAIT_DATA   = 2'h2
	} cache_state_e;

endpackage

//--- hw/icache.sv
////////////////////
// instruction cache
// direct-mapped, one 64-bit block per line, read only
// one outstanding block load per miss
////////////////////

`timescale 1ns/1ps

module icache #(
	parameter int ICACHE_LINES = 32
) (
	input  logic                 clock,
	input  logic                 reset,
	input  mem_sys_pkg::addr_t   fetch_addr,
	input  mem_sys_pkg::mem_tag_t ic_response,
	input  mem_sys_pkg::block_t  mem_rdata,
	input  mem_sys_pkg::mem_tag_t mem_rtag,
	output mem_sys_pkg::block_t  fetch_data,
	output logic                 fetch_valid,
	output mem_sys_pkg::bus_cmd_e ic_command,
	output mem_sys_pkg::addr_t   ic_addr
);
	import mem_sys_pkg::*;

	localparam int INDEX_BITS = $clog2(ICACHE_LINES);
	localparam int TAG_BITS   = $bits(addr_t) - INDEX_BITS - BLOCK_OFFSET_BITS;

	typedef logic [INDEX_BITS-1:0] index_t;
	typedef logic [TAG_BITS-1:0]   line_tag_t;

	// line storage
	block_t                  data_mem [ICACHE_LINES];
	line_tag_t               tag_mem  [ICACHE_LINES];
	logic [ICACHE_LINES-1:0] valid_mem;

	// lookup side
	index_t    fetch_index;
	line_tag_t fetch_tag;
	logic      hit;

	// miss side
	cache_state_e state;
	addr_t        miss_addr;
	index_t       miss_index;
	line_tag_t    miss_tag;
	mem_tag_t     wait_tag;
	logic         fill;

	////////////////////
	// lookup
	////////////////////

	// split the fetch address
	assign fetch_index = fetch_addr[BLOCK_OFFSET_BITS +: INDEX_BITS];
	assign fetch_tag   = fetch_addr[$bits(addr_t)-1 -: TAG_BITS];

	assign hit = valid_mem[fetch_index] && (tag_mem[fetch_index] == fetch_tag);

	// same cycle answer on a hit
	assign fetch_data  = data_mem[fetch_index];
	assign fetch_valid = hit;

	////////////////////
	// miss handling
	////////////////////

	// the latched miss address decides where the fill lands
	assign miss_index = miss_addr[BLOCK_OFFSET_BITS +: INDEX_BITS];
	assign miss_tag   = miss_addr[$bits(addr_t)-1 -: TAG_BITS];

	// block load presented until the arbiter passes a tag back
	assign ic_command = (state == CACHE_WAIT_ACCEPT) ? BUS_LOAD : BUS_NONE;
	assign ic_addr    = miss_addr;

	// reply for our own load
	assign fill = (state == CACHE_WAIT_DATA) && (mem_rtag == wait_tag);

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= CACHE_IDLE;
			valid_mem <= '0;
		end else begin
			case (state)
				CACHE_IDLE: begin
					if (!hit) begin
						state <= CACHE_WAIT_ACCEPT;
					end
				end
				CACHE_WAIT_ACCEPT: begin
					// zero response means refused, try again next cycle
					if (ic_response != '0) begin
						state <= CACHE_WAIT_DATA;
					end
				end
				CACHE_WAIT_DATA: begin
					if (fill) begin
						state                 <= CACHE_IDLE;
						valid_mem[miss_index] <= 1'b1;
					end
				end
				default: begin
					state <= CACHE_IDLE;
				end
			endcase
		end
	end

	// miss address, saved tag and line contents
	always_ff @(posedge clock) begin
		if (state == CACHE_IDLE && !hit) begin
			miss_addr <= {fetch_addr[$bits(addr_t)-1:BLOCK_OFFSET_BITS],
				{BLOCK_OFFSET_BITS{1'b0}}};
		end
		if (state == CACHE_WAIT_ACCEPT && ic_response != '0) begin
			wait_tag <= ic_response;
		end
		if (fill) begin
			data_mem[miss_index] <= mem_rdata;
			tag_mem[miss_index]  <= miss_tag;
		end
	end

endmodule

//--- hw/dcache.sv
////////////////////
// data cache
// direct-mapped, write-through, no write allocate
// double-word loads and stores only
////////////////////

`timescale 1ns/1ps

module dcache #(
	parameter int DCACHE_LINES = 16
) (
	input  logic                  clock,
	input  logic                  reset,
	input  mem_sys_pkg::bus_cmd_e dc_command,
	input  mem_sys_pkg::addr_t    dc_addr,
	input  mem_sys_pkg::block_t   dc_wdata,
	input  mem_sys_pkg::mem_tag_t dc_response,
	input  mem_sys_pkg::block_t   mem_rdata,
	input  mem_sys_pkg::mem_tag_t mem_rtag,
	output mem_sys_pkg::block_t   dc_rdata,
	output logic                  dc_finished,
	output mem_sys_pkg::bus_cmd_e dcm_command,
	output mem_sys_pkg::addr_t    dcm_addr,
	output mem_sys_pkg::block_t   dcm_wdata
);
	import mem_sys_pkg::*;

	localparam int INDEX_BITS = $clog2(DCACHE_LINES);
	localparam int TAG_BITS   = $bits(addr_t) - INDEX_BITS - BLOCK_OFFSET_BITS;

	typedef logic [INDEX_BITS-1:0] index_t;
	typedef logic [TAG_BITS-1:0]   line_tag_t;

	// line storage
	block_t                  data_mem [DCACHE_LINES];
	line_tag_t               tag_mem  [DCACHE_LINES];
	logic [DCACHE_LINES-1:0] valid_mem;

	// request decode
	index_t    req_index;
	line_tag_t req_tag;
	logic      is_load;
	logic      is_store;
	logic      hit;
	logic      load_hit;

	// memory side
	cache_state_e state;
	mem_tag_t     wait_tag;
	logic         accepted;
	logic         store_done;
	logic         fill;

	////////////////////
	// lookup
	////////////////////

	// request is held by the requester until dc_finished
	assign req_index = dc_addr[BLOCK_OFFSET_BITS +: INDEX_BITS];
	assign req_tag   = dc_addr[$bits(addr_t)-1 -: TAG_BITS];
	assign is_load   = (dc_command == BUS_LOAD);
	assign is_store  = (dc_command == BUS_STORE);

	assign hit      = valid_mem[req_index] && (tag_mem[req_index] == req_tag);
	assign load_hit = (state == CACHE_IDLE) && is_load && hit;

	////////////////////
	// memory requests
	////////////////////

	// loads fetch the whole block, stores write it through
	assign dcm_command = (state == CACHE_WAIT_ACCEPT) ? dc_command : BUS_NONE;
	assign dcm_addr    = {dc_addr[$bits(addr_t)-1:BLOCK_OFFSET_BITS], {BLOCK_OFFSET_BITS{1'b0}}};
	assign dcm_wdata   = dc_wdata;

	// nonzero response means the arbiter got us a tag
	assign accepted   = (state == CACHE_WAIT_ACCEPT) && (dc_response != '0);
	assign store_done = accepted && is_store;

	// our load reply
	assign fill = (state == CACHE_WAIT_DATA) && (mem_rtag == wait_tag);

	// three ways to finish
	assign dc_finished = load_hit || store_done || fill;

	// miss data straight from the bus, hit data from the array
	assign dc_rdata = (state == CACHE_WAIT_DATA) ? mem_rdata : data_mem[req_index];

	////////////////////
	// state machine
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state     <= CACHE_IDLE;
			valid_mem <= '0;
		end else begin
			case (state)
				CACHE_IDLE: begin
					// every store and every load miss goes out to memory
					if (is_store || (is_load && !hit)) begin
						state <= CACHE_WAIT_ACCEPT;
					end
				end
				CACHE_WAIT_ACCEPT: begin
					if (accepted) begin
						state <= is_store ? CACHE_IDLE : CACHE_WAIT_DATA;
					end
				end
				CACHE_WAIT_DATA: begin
					if (fill) begin
						state                <= CACHE_IDLE;
						valid_mem[req_index] <= 1'b1;
					end
				end
				default: begin
					state <= CACHE_IDLE;
				end
			endcase
		end
	end

	// saved tag and line contents
	always_ff @(posedge clock) begin
		if (accepted) begin
			wait_tag <= dc_response;
		end
		if (fill) begin
			data_mem[req_index] <= mem_rdata;
			tag_mem[req_index]  <= req_tag;
		end else if (store_done && hit) begin
			// store hit keeps the line in step with memory
			data_mem[req_index] <= dc_wdata;
		end
	end

endmodule

//--- hw/mem_arbiter.sv
////////////////////
// memory arbiter
// merges both caches onto the tagged memory bus,
// data cache first, and routes replies by owner tag
////////////////////

`timescale 1ns/1ps

module mem_arbiter (
	input  logic                  clock,
	input  logic                  reset,
	input  mem_sys_pkg::bus_cmd_e ic_command,
	input  mem_sys_pkg::addr_t    ic_addr,
	input  mem_sys_pkg::bus_cmd_e dcm_command,
	input  mem_sys_pkg::addr_t    dcm_addr,
	input  mem_sys_pkg::block_t   dcm_wdata,
	input  mem_sys_pkg::mem_tag_t mem_response,
	input  mem_sys_pkg::mem_tag_t mem_rtag,
	output mem_sys_pkg::mem_tag_t ic_response,
	output mem_sys_pkg::mem_tag_t dc_response,
	output mem_sys_pkg::mem_tag_t ic_rtag,
	output mem_sys_pkg::mem_tag_t dc_rtag,
	output mem_sys_pkg::bus_cmd_e mem_command,
	output mem_sys_pkg::addr_t    mem_addr,
	output mem_sys_pkg::block_t   mem_wdata
);
	import mem_sys_pkg::*;

	localparam int TAGS = 1 << $bits(mem_tag_t);

	// grant
	logic grant_dc;
	logic ic_active;
	logic load_accepted;

	// owner table, one entry per tag
	logic [TAGS-1:0] owner_valid;
	logic [TAGS-1:0] owner_dc;

	////////////////////
	// request side
	////////////////////

	// data cache wins whenever it asks
	assign grant_dc  = (dcm_command != BUS_NONE);
	assign ic_active = !grant_dc && (ic_command != BUS_NONE);

	assign mem_command = grant_dc ? dcm_command : ic_command;
	assign mem_addr    = grant_dc ? dcm_addr : ic_addr;
	// only the data cache ever writes
	assign mem_wdata   = grant_dc ? dcm_wdata : '0;

	// the side that lost sees a refusal and retries
	assign dc_response = grant_dc ? mem_response : '0;
	assign ic_response = ic_active ? mem_response : '0;

	// a load that memory took, its tag now has an owner
	assign load_accepted = (mem_command == BUS_LOAD) && (mem_response != '0);

	////////////////////
	// owner table
	////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			owner_valid <= '0;
		end else begin
			// reply frees its tag
			if (mem_rtag != '0) begin
				owner_valid[mem_rtag] <= 1'b0;
			end
			// a tag reused in the same cycle stays taken
			if (load_accepted) begin
				owner_valid[mem_response] <= 1'b1;
			end
		end
	end

	// which side holds the tag
	always_ff @(posedge clock) begin
		if (load_accepted) begin
			owner_dc[mem_response] <= grant_dc;
		end
	end

	////////////////////
	// reply side
	////////////////////

	// each cache only sees reply tags that it owns
	assign dc_rtag = (owner_valid[mem_rtag] && owner_dc[mem_rtag]) ? mem_rtag : '0;
	assign ic_rtag = (owner_valid[mem_rtag] && !owner_dc[mem_rtag]) ? mem_rtag : '0;

endmodule

//--- hw/mem_sys.sv
////////////////////
// memory system top
// instruction cache and data cache side by side,
// sharing one tagged memory bus through the arbiter
////////////////////

`timescale 1ns/1ps

module mem_sys #(
	parameter int ICACHE_LINES = 32,
	parameter int DCACHE_LINES = 16
) (
	input  logic                  clock,
	input  logic                  reset,
	input  mem_sys_pkg::addr_t    fetch_addr,
	input  mem_sys_pkg::bus_cmd_e dc_command,
	input  mem_sys_pkg::addr_t    dc_addr,
	input  mem_sys_pkg::block_t   dc_wdata,
	input  mem_sys_pkg::mem_tag_t mem_response,
	input  mem_sys_pkg::block_t   mem_rdata,
	input  mem_sys_pkg::mem_tag_t mem_rtag,
	output mem_sys_pkg::block_t   fetch_data,
	output logic                  fetch_valid,
	output mem_sys_pkg::block_t   dc_rdata,
	output logic                  dc_finished,
	output mem_sys_pkg::bus_cmd_e mem_command,
	output mem_sys_pkg::addr_t    mem_addr,
	output mem_sys_pkg::block_t   mem_wdata
);
	import mem_sys_pkg::*;

	// icache to arbiter
	bus_cmd_e ic_command;
	addr_t    ic_addr;
	mem_tag_t ic_response;
	mem_tag_t ic_rtag;

	// dcache to arbiter
	bus_cmd_e dcm_command;
	addr_t    dcm_addr;
	block_t   dcm_wdata;
	mem_tag_t dc_response;
	mem_tag_t dc_rtag;

	////////////////////
	// caches
	////////////////////

	// reply data is shared, tags come filtered by owner
	icache #(.ICACHE_LINES(ICACHE_LINES)) u_icache (
		.clock(clock),
		.reset(reset),
		.fetch_addr(fetch_addr),
		.ic_response(ic_response),
		.mem_rdata(mem_rdata),
		.mem_rtag(ic_rtag),
		.fetch_data(fetch_data),
		.fetch_valid(fetch_valid),
		.ic_command(ic_command),
		.ic_addr(ic_addr)
	);

	dcache #(.DCACHE_LINES(DCACHE_LINES)) u_dcache (
		.clock(clock),
		.reset(reset),
		.dc_command(dc_command),
		.dc_addr(dc_addr),
		.dc_wdata(dc_wdata),
		.dc_response(dc_response),
		.mem_rdata(mem_rdata),
		.mem_rtag(dc_rtag),
		.dc_rdata(dc_rdata),
		.dc_finished(dc_finished),
		.dcm_command(dcm_command),
		.dcm_addr(dcm_addr),
		.dcm_wdata(dcm_wdata)
	);

	////////////////////
	// arbiter
	////////////////////

	mem_arbiter u_mem_arbiter (
		.clock(clock),
		.reset(reset),
		.ic_command(ic_command),
		.ic_addr(ic_addr),
		.dcm_command(dcm_command),
		.dcm_addr(dcm_addr),
		.dcm_wdata(dcm_wdata),
		.mem_response(mem_response),
		.mem_rtag(mem_rtag),
		.ic_response(ic_response),
		.dc_response(dc_response),
		.ic_rtag(ic_rtag),
		.dc_rtag(dc_rtag),
		.mem_command(mem_command),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata)
	);

endmodule

//--- verif/tb_clock_gen.sv
////////////////////
// testbench clock and reset
// 40 ns period, reset high for 2 cycles
////////////////////

`timescale 1ns/1ps

module tb_clock_gen (
	output logic clock,
	output logic reset
);

	// half period 20 ns
	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// released on the second rising edge
	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

//--- verif/mem_word.svh
////////////////////
// memory reference pattern
// initial contents of every double word,
// mixed from all the address bits
////////////////////

// both halves depend on the whole address
function automatic mem_sys_pkg::block_t mem_word(input mem_sys_pkg::addr_t a);
	logic [31:0] hi;
	logic [31:0] lo;
	hi = a ^ 32'hA5C3_0F17;
	lo = {a[15:0], a[31:16]} + 32'h1357_9BDF;
	return {hi, lo};
endfunction

//--- verif/tb_mem_model.sv
////////////////////
// tagged memory model
// accepts 3 of 4 requests, tags 1 to 15,
// load replies after 1 to 6 cycles
////////////////////

`timescale 1ns/1ps

module tb_mem_model (
	input  logic                  clock,
	input  logic                  reset,
	input  mem_sys_pkg::bus_cmd_e mem_command,
	input  mem_sys_pkg::addr_t    mem_addr,
	input  mem_sys_pkg::block_t   mem_wdata,
	output mem_sys_pkg::mem_tag_t mem_response,
	output mem_sys_pkg::block_t   mem_rdata,
	output mem_sys_pkg::mem_tag_t mem_rtag
);
	import mem_sys_pkg::*;

	`include "mem_word.svh"

	// shadow of memory, untouched locations follow the pattern
	block_t shadow [addr_t];

	// loads in flight
	mem_tag_t pend_tag  [$];
	block_t   pend_data [$];
	int       pend_wait [$];

	logic [15:0] tag_busy;
	logic        accept_en;
	mem_tag_t    next_tag;

	// accept in the same cycle, zero means refused
	assign mem_response = (mem_command != BUS_NONE && accept_en) ? next_tag : '0;

	function automatic block_t read_block(input addr_t a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return mem_word(a);
	endfunction

	always @(posedge clock) begin
		int       ready;
		int       cand;
		mem_tag_t pick;
		if (reset) begin
			pend_tag.delete();
			pend_data.delete();
			pend_wait.delete();
			tag_busy = '0;
			accept_en <= 1'b0;
			next_tag  <= 4'h1;
			mem_rtag  <= '0;
			mem_rdata <= '0;
		end else begin
			// age the pending loads
			ready = -1;
			foreach (pend_wait[i]) begin
				if (pend_wait[i] > 0) begin
					pend_wait[i] = pend_wait[i] - 1;
				end
			end
			foreach (pend_wait[i]) begin
				if (pend_wait[i] == 0 && ready < 0) begin
					ready = i;
				end
			end
			// one reply per cycle
			if (ready >= 0) begin
				mem_rtag  <= pend_tag[ready];
				mem_rdata <= pend_data[ready];
				tag_busy[pend_tag[ready]] = 1'b0;
				pend_tag.delete(ready);
				pend_data.delete(ready);
				pend_wait.delete(ready);
			end else begin
				mem_rtag <= '0;
			end
			// request taken this cycle
			if (mem_command != BUS_NONE && mem_response != '0) begin
				if (mem_command == BUS_STORE) begin
					shadow[mem_addr] = mem_wdata;
				end else begin
					pend_tag.push_back(mem_response);
					pend_data.push_back(read_block(mem_addr));
					pend_wait.push_back(int'($urandom_range(1, 6)));
					tag_busy[mem_response] = 1'b1;
				end
			end
			// next free tag, rotating through 1 to 15
			pick = '0;
			for (int k = 1; k < 16; k++) begin
				cand = (int'(next_tag) + k - 1) % 15 + 1;
				if (!tag_busy[cand] && pick == '0) begin
					pick = mem_tag_t'(cand);
				end
			end
			next_tag  <= pick;
			accept_en <= ($urandom % 4) != 0;
		end
	end

endmodule

//--- verif/tb_mem_sys.sv
////////////////////
// memory system testbench
// directed and random fetches, loads and stores
// against a reference pattern and an expected memory
////////////////////

`timescale 1ns/1ps

module tb_mem_sys;
	import mem_sys_pkg::*;

	`include "mem_word.svh"

	localparam int TIMEOUT = 400;

	logic     clock;
	logic     reset;
	addr_t    fetch_addr;
	bus_cmd_e dc_command;
	addr_t    dc_addr;
	block_t   dc_wdata;
	mem_tag_t mem_response;
	block_t   mem_rdata;
	mem_tag_t mem_rtag;
	block_t   fetch_data;
	logic     fetch_valid;
	block_t   dc_rdata;
	logic     dc_finished;
	bus_cmd_e mem_command;
	addr_t    mem_addr;
	block_t   mem_wdata;

	// what memory should hold after the stores so far
	block_t exp_mem [addr_t];

	tb_clock_gen u_clock_gen (.clock(clock), .reset(reset));

	mem_sys u_dut (
		.clock(clock), .reset(reset),
		.fetch_addr(fetch_addr),
		.dc_command(dc_command), .dc_addr(dc_addr), .dc_wdata(dc_wdata),
		.mem_response(mem_response), .mem_rdata(mem_rdata), .mem_rtag(mem_rtag),
		.fetch_data(fetch_data), .fetch_valid(fetch_valid),
		.dc_rdata(dc_rdata), .dc_finished(dc_finished),
		.mem_command(mem_command), .mem_addr(mem_addr), .mem_wdata(mem_wdata)
	);

	tb_mem_model u_mem (
		.clock(clock), .reset(reset),
		.mem_command(mem_command), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
		.mem_response(mem_response), .mem_rdata(mem_rdata), .mem_rtag(mem_rtag)
	);

	////////////////////
	// reference and checks
	////////////////////

	function automatic addr_t align(input addr_t a);
		return {a[31:3], 3'b000};
	endfunction

	// latest store wins, else the pattern
	function automatic block_t expected_load(input addr_t a);
		if (exp_mem.exists(align(a))) begin
			return exp_mem[align(a)];
		end
		return mem_word(align(a));
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_block(input string name, input block_t got, input block_t exp);
		if (got !== exp) begin
			stop_run($sformatf("MISMATCH %s got 0x%016h expected 0x%016h", name, got, exp));
		end
	endtask

	task automatic check_fetch(input block_t got_data, input logic got_valid,
		input block_t exp_data);
		if (got_valid !== 1'b1) begin
			stop_run($sformatf("MISMATCH fetch_valid got 0x%0h expected 0x1", got_valid));
		end
		check_block("fetch_data", got_data, exp_data);
	endtask

	task automatic check_addr(input string name, input addr_t got, input addr_t exp);
		if (got !== exp) begin
			stop_run($sformatf("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp));
		end
	endtask

	task automatic check_cmd(input string name, input bus_cmd_e got, input bus_cmd_e exp);
		if (got !== exp) begin
			stop_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			stop_run($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
		end
	endtask

	// every answer the DUT gives is compared here
	always @(negedge clock) begin
		if (!reset) begin
			if (fetch_valid) begin
				check_fetch(fetch_data, fetch_valid, mem_word(align(fetch_addr)));
			end
			if (dc_finished && dc_command == BUS_LOAD) begin
				check_block("dc_rdata", dc_rdata, expected_load(dc_addr));
			end
			// write-through store carries the held request
			if (mem_command == BUS_STORE) begin
				check_addr("mem_addr", mem_addr, align(dc_addr));
				check_block("mem_wdata", mem_wdata, dc_wdata);
			end
		end
	end

	////////////////////
	// stimulus tasks
	////////////////////

	// hold the address until fetch_valid, cycles is 0 on a hit
	task automatic fetch(input addr_t a, input logic must_hit, output int cycles);
		int n;
		n = 0;
		@(posedge clock);
		fetch_addr <= a;
		@(negedge clock);
		if (must_hit) begin
			check_fetch(fetch_data, fetch_valid, mem_word(align(a)));
		end
		while (!fetch_valid) begin
			n = n + 1;
			if (n > TIMEOUT) begin
				stop_run($sformatf("timeout waiting for fetch of 0x%08h", a));
			end
			@(negedge clock);
		end
		cycles = n;
	endtask

	// one data request, dropped in the cycle after dc_finished
	task automatic dc_access(input bus_cmd_e cmd, input addr_t a, input block_t wd,
		output int cycles);
		int n;
		n = 0;
		@(posedge clock);
		dc_command <= cmd;
		dc_addr    <= a;
		dc_wdata   <= wd;
		@(negedge clock);
		while (!dc_finished) begin
			n = n + 1;
			if (n > TIMEOUT) begin
				stop_run($sformatf("timeout waiting for data access at 0x%08h", a));
			end
			@(negedge clock);
		end
		if (cmd == BUS_STORE) begin
			exp_mem[align(a)] = wd;
		end
		cycles = n;
		@(posedge clock);
		dc_command <= BUS_NONE;
	endtask

	////////////////////
	// test sequence
	////////////////////

	initial begin
		int     cyc;
		int     n;
		int     fcyc;
		int     dcyc;
		addr_t  ra;
		block_t rd;
		void'($urandom(82));
		fetch_addr = '0;
		dc_command = BUS_NONE;
		dc_addr    = '0;
		dc_wdata   = '0;

		// idle outputs right after reset
		n = 0;
		while (reset !== 1'b0) begin
			n = n + 1;
			if (n > 20) begin
				stop_run("reset never released");
			end
			@(negedge clock);
		end
		check_cmd("mem_command", mem_command, BUS_NONE);
		check_flag("fetch_valid", fetch_valid, 1'b0);
		check_flag("dc_finished", dc_finished, 1'b0);

		// fetch miss then hits in the same block
		fetch(32'h0000_1040, 1'b0, cyc);
		fetch(32'h0000_1040, 1'b1, cyc);
		fetch(32'h0000_1044, 1'b1, cyc);

		// load miss then hit
		dc_access(BUS_LOAD, 32'h0002_0100, '0, cyc);
		if (cyc == 0) stop_run("first load of a line answered as a hit");
		dc_access(BUS_LOAD, 32'h0002_0100, '0, cyc);
		if (cyc != 0) stop_run("repeated load did not hit");

		// store miss must not allocate
		dc_access(BUS_STORE, 32'h0002_0208, 64'h1122_3344_5566_7788, cyc);
		dc_access(BUS_LOAD, 32'h0002_0208, '0, cyc);
		if (cyc == 0) stop_run("store miss allocated a line");
		dc_access(BUS_LOAD, 32'h0002_0208, '0, cyc);
		if (cyc != 0) stop_run("load after fill did not hit");
		// store hit updates line and memory
		dc_access(BUS_STORE, 32'h0002_0208, 64'hCAFE_F00D_DEAD_BEEF, cyc);
		dc_access(BUS_LOAD, 32'h0002_0208, '0, cyc);
		if (cyc != 0) stop_run("load after store hit did not hit");
		dc_access(BUS_LOAD, 32'h0002_0288, '0, cyc);
		dc_access(BUS_LOAD, 32'h0002_0208, '0, cyc);
		if (cyc == 0) stop_run("evicted data line still hit");

		// index collisions, 256 bytes apart in icache, 128 in dcache
		fetch(32'h0000_1100, 1'b0, cyc);
		fetch(32'h0000_1200, 1'b0, cyc);
		fetch(32'h0000_1100, 1'b0, cyc);
		if (cyc == 0) stop_run("evicted instruction line still hit");
		dc_access(BUS_LOAD, 32'h0002_0300, '0, cyc);
		dc_access(BUS_LOAD, 32'h0002_0380, '0, cyc);
		dc_access(BUS_LOAD, 32'h0002_0300, '0, cyc);
		if (cyc == 0) stop_run("evicted data line still hit");

		// both caches busy at once under random refusals
		fork
			begin
				for (int i = 0; i < 60; i++) begin
					fetch(32'h0000_1000 + ($urandom % 128) * 8 + ($urandom % 8), 1'b0, fcyc);
				end
			end
			begin
				for (int i = 0; i < 60; i++) begin
					ra = 32'h0002_0000 + ($urandom % 64) * 8;
					rd = {$urandom, $urandom};
					if ($urandom % 4 == 0) begin
						dc_access(BUS_STORE, ra, rd, dcyc);
					end else begin
						dc_access(BUS_LOAD, ra, '0, dcyc);
					end
				end
			end
		join

		$display("Test completed successfully");
		$finish;
	end

endmodule

//--- mem_sys.f
hw/mem_sys_pkg.sv
hw/icache.sv
hw/dcache.sv
hw/mem_arbiter.sv
hw/mem_sys.sv
+incdir+verif
verif/tb_clock_gen.sv
verif/tb_mem_model.sv
verif/tb_mem_sys.sv

//--- Makefile
SIM := obj_dir/Vtb_mem_sys

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): mem_sys.f hw/*.sv verif/*.sv verif/*.svh
	verilator --binary --timing --top-module tb_mem_sys -f mem_sys.f

# exit status of the simulator is the test result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
